// ==== Makefile ====
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing --assert -Wall
TOP        = graph_ctrl_tb
FILELIST   = graph_ctrl.f
OBJ_DIR    = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q '^TEST PASS$$'

clean:
	rm -rf $(OBJ_DIR)

// ==== graph_ctrl.f ====
src/graph_ctrl_pkg.sv
src/sync_fifo.sv
src/rr_arbiter.sv
src/vertex_cu.sv
src/vertex_job_dispatch.sv
src/read_command_mux.sv
src/graph_ctrl_top.sv
sim/graph_ctrl_props.sv
sim/graph_ctrl_tb.sv

// ==== sim/graph_ctrl_props.sv ====
`timescale 1ns/1ps

module graph_ctrl_props (
	input logic                                clock,
	input logic                                rstn,
	input logic                                issue,
	input logic [graph_ctrl_pkg::CREDIT_W-1:0] credits,
	input logic                                read_cmd_valid
);

	import graph_ctrl_pkg::*;

	// a grant spends a credit, so it needs one
	assert property (@(posedge clock) disable iff (!rstn) issue |-> (credits != '0))
		else $error("command granted with no read credit left");

	assert property (@(posedge clock) disable iff (!rstn) credits <= CREDIT_W'(READ_CREDITS))
		else $error("read credit counter above its reset value");

	// first edge out of reset
	assert property (@(posedge clock) $rose(rstn) |-> !read_cmd_valid)
		else $error("read command valid high right after reset");

endmodule

bind read_command_mux graph_ctrl_props u_props (
	.clock         (clock),
	.rstn          (rstn),
	.issue         (issue),
	.credits       (credits),
	.read_cmd_valid(read_cmd_valid)
);

// ==== sim/graph_ctrl_tb.sv ====
`timescale 1ns/1ps

module graph_ctrl_tb;

	import graph_ctrl_pkg::*;

	localparam int NUM_JOBS  = 12;
	localparam int NUM_WORDS = NUM_JOBS * 3 + 2;
	localparam int NUM_TESTS = 5;
	localparam int T_RESET   = 0;
	localparam int T_ADDR    = 1;
	localparam int T_CREDIT  = 2;
	localparam int T_JOBCRED = 3;
	localparam int T_TOTALS  = 4;

	logic        clock;
	logic        rstn;
	logic        job_valid;
	vertex_id_t  job_vertex;
	addr_t       job_base;
	edge_count_t job_edges;
	logic        job_credit;
	logic        read_cmd_valid;
	addr_t       read_cmd_addr;
	cu_id_t      read_cmd_cu_id;
	logic        read_credit;
	logic        read_data_valid;
	data_t       read_data;
	cu_id_t      read_data_cu_id;
	count_t      vertices_done;
	count_t      edges_done;

	logic [31:0] vectors [NUM_WORDS];
	integer      seed;
	string       test_names [NUM_TESTS];
	int          test_errors [NUM_TESTS];
	int          checks;
	int          watchdog_cycles;
	int          cycle;
	int          cmds_seen;
	int          credits_back;
	int          job_credits_seen;
	int          exhausted_cycles;
	int          stall_left;
	logic        running;
	int          issued_cnt [addr_t];
	int          routed_cnt [addr_t];
	cu_id_t      issued_tag [addr_t];
	addr_t       pend_addr [$];
	cu_id_t      pend_tag [$];
	int          pend_due [$];

	graph_ctrl_top u_dut (
		.clock          (clock),
		.rstn           (rstn),
		.job_valid      (job_valid),
		.job_vertex     (job_vertex),
		.job_base       (job_base),
		.job_edges      (job_edges),
		.job_credit     (job_credit),
		.read_cmd_valid (read_cmd_valid),
		.read_cmd_addr  (read_cmd_addr),
		.read_cmd_cu_id (read_cmd_cu_id),
		.read_credit    (read_credit),
		.read_data_valid(read_data_valid),
		.read_data      (read_data),
		.read_data_cu_id(read_data_cu_id),
		.vertices_done  (vertices_done),
		.edges_done     (edges_done)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	////////////////////////////////////////////////////////////
	// check helpers
	////////////////////////////////////////////////////////////

	task automatic check_value(input int test, input string what, input longint expected,
			input longint actual);
		checks++;
		assert (expected == actual) else begin
			$display("MISMATCH %s: %s expected %0h actual %0h", test_names[test], what,
				expected, actual);
			test_errors[test]++;
		end
	endtask

	task automatic check_true(input int test, input bit cond, input string msg);
		checks++;
		assert (cond) else begin
			$display("ERROR %s: %s", test_names[test], msg);
			test_errors[test]++;
		end
	endtask

	task automatic report_test(input int test);
		if (test_errors[test] == 0)
			$display("test %s: ok", test_names[test]);
		else
			$display("test %s: failed with %0d errors", test_names[test], test_errors[test]);
	endtask

	function automatic bit in_job_range(input addr_t a);
		bit hit;
		hit = 1'b0;
		for (int j = 0; j < NUM_JOBS; j++) begin
			if (a >= vectors[3*j+1] && a < vectors[3*j+1] + vectors[3*j+2])
				hit = 1'b1;
		end
		return hit;
	endfunction

	////////////////////////////////////////////////////////////
	// observation at the falling edge
	////////////////////////////////////////////////////////////

	always @(negedge clock) begin : observe
		addr_t a;
		int    unit;
		int    outstanding;
		cycle++;
		if (running) begin
			if (job_credit)
				job_credits_seen++;
			if (read_cmd_valid) begin
				a = read_cmd_addr;
				check_true(T_ADDR, in_job_range(a),
					$sformatf("address %08h issued outside every job range", a));
				if (issued_cnt.exists(a))
					issued_cnt[a]++;
				else
					issued_cnt[a] = 1;
				check_value(T_ADDR, $sformatf("issue count of address %08h", a), 1,
					issued_cnt[a]);
				issued_tag[a] = read_cmd_cu_id;
				cmds_seen++;
				pend_addr.push_back(a);
				pend_tag.push_back(read_cmd_cu_id);
				pend_due.push_back(cycle + 1 + int'($unsigned($random(seed)) % 12));
			end
			outstanding = cmds_seen - credits_back;
			check_true(T_CREDIT, outstanding <= READ_CREDITS,
				$sformatf("%0d read commands outstanding", outstanding));
			if (outstanding == READ_CREDITS)
				exhausted_cycles++;
			// the datum as the unit sees it
			if (u_dut.rd_valid_q != '0) begin
				unit = 0;
				for (int i = 0; i < NUM_CU; i++) begin
					if (u_dut.rd_valid_q[i])
						unit = i;
				end
				a = u_dut.rd_data_q;
				check_value(T_ADDR, $sformatf("units reached by address %08h", a), 1,
					$countones(u_dut.rd_valid_q));
				check_true(T_ADDR, issued_tag.exists(a),
					$sformatf("data %08h routed for an address never issued", a));
				if (issued_tag.exists(a))
					check_value(T_ADDR, $sformatf("unit for address %08h", a),
						issued_tag[a], unit);
				if (routed_cnt.exists(a))
					routed_cnt[a]++;
				else
					routed_cnt[a] = 1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// memory model
	////////////////////////////////////////////////////////////

	always @(posedge clock) begin : memory_model
		int pick;
		#2;
		read_data_valid = 1'b0;
		read_credit     = 1'b0;
		if (running) begin
			if (stall_left > 0) begin
				stall_left--;
			end else begin
				// now and then hold every credit back for a while
				if (($unsigned($random(seed)) % 40) == 0)
					stall_left = 20 + int'($unsigned($random(seed)) % 30);
				pick = -1;
				for (int i = 0; i < pend_addr.size(); i++) begin
					if (pick < 0 && pend_due[i] <= cycle)
						pick = i;
				end
				if (pick >= 0) begin
					read_data_valid = 1'b1;
					read_data       = pend_addr[pick];
					read_data_cu_id = pend_tag[pick];
					read_credit     = 1'b1;
					credits_back++;
					pend_addr.delete(pick);
					pend_tag.delete(pick);
					pend_due.delete(pick);
				end
			end
		end
	end

	initial begin : watchdog
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles) @(posedge clock);
		$display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
		$display("TEST FAIL");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin : main
		int   sent;
		int   credits;
		int   sum_edges;
		int   failed;
		int   errors;
		addr_t a;
		rstn            = 1'b0;
		job_valid       = 1'b0;
		job_vertex      = '0;
		job_base        = '0;
		job_edges       = '0;
		read_credit     = 1'b0;
		read_data_valid = 1'b0;
		read_data       = '0;
		read_data_cu_id = '0;
		running         = 1'b0;
		seed            = 32'he278accc;
		test_names[T_RESET]   = "reset_values";
		test_names[T_ADDR]    = "addresses_and_tags";
		test_names[T_CREDIT]  = "read_credit_limit";
		test_names[T_JOBCRED] = "job_credits";
		test_names[T_TOTALS]  = "final_totals";
		$readmemh("sim/graph_ctrl_vectors.txt", vectors);
		sum_edges = 0;
		for (int j = 0; j < NUM_JOBS; j++)
			sum_edges += int'(vectors[3*j+2]);
		watchdog_cycles = 200 * sum_edges;

		repeat (2) @(posedge clock);
		#2 rstn = 1'b1;
		@(negedge clock);
		check_value(T_RESET, "read_cmd_valid", 0, read_cmd_valid);
		check_value(T_RESET, "job_credit", 0, job_credit);
		check_value(T_RESET, "vertices_done", 0, vertices_done);
		check_value(T_RESET, "edges_done", 0, edges_done);
		report_test(T_RESET);

		// memory starts out stalled so credits run dry early
		stall_left = 40;
		running    = 1'b1;
		sent       = 0;
		while (sent < NUM_JOBS) begin
			@(posedge clock);
			#2;
			credits = JOB_FIFO_DEPTH - sent + job_credits_seen;
			if (credits > 0) begin
				job_valid  = 1'b1;
				job_vertex = vertex_id_t'(vectors[3*sent]);
				job_base   = addr_t'(vectors[3*sent+1]);
				job_edges  = edge_count_t'(vectors[3*sent+2]);
				sent++;
			end else begin
				job_valid = 1'b0;
			end
		end
		@(posedge clock);
		#2 job_valid = 1'b0;

		while (vertices_done < count_t'(vectors[NUM_WORDS-2]) || pend_addr.size() != 0)
			@(negedge clock);

		for (int j = 0; j < NUM_JOBS; j++) begin
			for (int k = 0; k < int'(vectors[3*j+2]); k++) begin
				a = addr_t'(vectors[3*j+1] + k);
				check_value(T_ADDR, $sformatf("issue count of address %08h", a), 1,
					issued_cnt.exists(a) ? issued_cnt[a] : 0);
				check_value(T_ADDR, $sformatf("data count of address %08h", a), 1,
					routed_cnt.exists(a) ? routed_cnt[a] : 0);
			end
		end
		report_test(T_ADDR);

		check_true(T_CREDIT, exhausted_cycles > 0, "read credits never ran out");
		// one read per edge must get through the credit limit
		check_value(T_CREDIT, "read commands issued", vectors[NUM_WORDS-1], cmds_seen);
		report_test(T_CREDIT);

		check_value(T_JOBCRED, "job credit pulses", NUM_JOBS, job_credits_seen);
		report_test(T_JOBCRED);

		check_value(T_TOTALS, "vertices_done", vectors[NUM_WORDS-2], vertices_done);
		check_value(T_TOTALS, "edges_done", vectors[NUM_WORDS-1], edges_done);
		report_test(T_TOTALS);

		failed = 0;
		errors = 0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			if (test_errors[t] != 0)
				failed++;
			errors += test_errors[t];
		end
		$display("tests %0d, failed %0d, checks %0d, errors %0d", NUM_TESTS, failed,
			checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== sim/graph_ctrl_vectors.txt ====
// one job per line: vertex id, base address, edge count
// last two lines: expected vertices done, expected edges done
00000001 00001000 00000005
00000002 00002000 00000003
00000003 00003000 00000000
00000004 00004000 00000008
00000005 00005000 0000000c
00000006 00006000 00000001
00000007 00007000 00000006
00000008 00008000 0000000a
00000009 00009000 00000002
0000000a 0000a000 00000009
0000000b 0000b000 00000004
0000000c 0000c000 00000007
0000000c
00000043

// ==== src/graph_ctrl_pkg.sv ====
package graph_ctrl_pkg;

	////////////////////////////////////////////////////////////
	// sizes
	////////////////////////////////////////////////////////////

	localparam int NUM_CU         = 4;
	localparam int CU_ID_W        = $clog2(NUM_CU);
	localparam int VERTEX_W       = 16;
	localparam int EDGE_W         = 16;
	localparam int ADDR_W         = 32;
	localparam int DATA_W         = 32;
	localparam int COUNT_W        = 32;

	// job depth doubles as the upstream credit count
	localparam int JOB_FIFO_DEPTH = 16;
	localparam int CMD_FIFO_DEPTH = 8;
	localparam int READ_CREDITS   = 4;
	localparam int CREDIT_W       = $clog2(READ_CREDITS + 1);

	////////////////////////////////////////////////////////////
	// types
	////////////////////////////////////////////////////////////

	typedef logic [CU_ID_W-1:0]  cu_id_t;
	typedef logic [VERTEX_W-1:0] vertex_id_t;
	typedef logic [EDGE_W-1:0]   edge_count_t;
	typedef logic [ADDR_W-1:0]   addr_t;
	typedef logic [DATA_W-1:0]   data_t;
	typedef logic [COUNT_W-1:0]  count_t;

	typedef enum logic [1:0] {CU_IDLE, CU_ISSUE, CU_WAIT} cu_state_e;

endpackage

// ==== src/graph_ctrl_top.sv ====
`timescale 1ns/1ps

module graph_ctrl_top (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       job_valid,
	input  graph_ctrl_pkg::vertex_id_t  job_vertex,
	input  graph_ctrl_pkg::addr_t       job_base,
	input  graph_ctrl_pkg::edge_count_t job_edges,
	output logic                       job_credit,
	output logic                       read_cmd_valid,
	output graph_ctrl_pkg::addr_t       read_cmd_addr,
	output graph_ctrl_pkg::cu_id_t      read_cmd_cu_id,
	input  logic                       read_credit,
	input  logic                       read_data_valid,
	input  graph_ctrl_pkg::data_t       read_data,
	input  graph_ctrl_pkg::cu_id_t      read_data_cu_id,
	output graph_ctrl_pkg::count_t      vertices_done,
	output graph_ctrl_pkg::count_t      edges_done
);

	import graph_ctrl_pkg::*;

	logic [NUM_CU-1:0] cu_idle;
	logic [NUM_CU-1:0] cu_job_valid;
	addr_t             cu_job_base;
	edge_count_t       cu_job_edges;
	logic [NUM_CU-1:0] cmd_push;
	logic [NUM_CU-1:0] cmd_full;
	addr_t             cmd_addr [NUM_CU];
	logic [NUM_CU-1:0] vertex_done;
	edge_count_t       done_edges [NUM_CU];
	logic [NUM_CU-1:0] rd_route;
	logic [NUM_CU-1:0] rd_valid_q;
	data_t             rd_data_q;
	count_t            vertex_sum;
	count_t            edge_sum;

	vertex_job_dispatch u_dispatch (
		.clock       (clock),
		.rstn        (rstn),
		.job_valid   (job_valid),
		.job_vertex  (job_vertex),
		.job_base    (job_base),
		.job_edges   (job_edges),
		.job_credit  (job_credit),
		.cu_idle     (cu_idle),
		.cu_job_valid(cu_job_valid),
		.cu_job_base (cu_job_base),
		.cu_job_edges(cu_job_edges)
	);

	read_command_mux u_cmd_mux (
		.clock         (clock),
		.rstn          (rstn),
		.cmd_push      (cmd_push),
		.cmd_addr      (cmd_addr),
		.cmd_full      (cmd_full),
		.read_credit   (read_credit),
		.read_cmd_valid(read_cmd_valid),
		.read_cmd_addr (read_cmd_addr),
		.read_cmd_cu_id(read_cmd_cu_id)
	);

	////////////////////////////////////////////////////////////
	// read data routing by tag
	////////////////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < NUM_CU; i++)
			rd_route[i] = read_data_valid && (read_data_cu_id == cu_id_t'(i));
	end

	always_ff @(posedge clock) begin
		rd_data_q <= read_data;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			rd_valid_q <= '0;
		else
			rd_valid_q <= rd_route;
	end

	for (genvar i = 0; i < NUM_CU; i++) begin : g_cu
		vertex_cu #(.CU_ID(i)) u_cu (
			.clock      (clock),
			.rstn       (rstn),
			.cu_idle    (cu_idle[i]),
			.job_valid  (cu_job_valid[i]),
			.job_base   (cu_job_base),
			.job_edges  (cu_job_edges),
			.cmd_push   (cmd_push[i]),
			.cmd_addr   (cmd_addr[i]),
			.cmd_full   (cmd_full[i]),
			.data_valid (rd_valid_q[i]),
			.data       (rd_data_q),
			.vertex_done(vertex_done[i]),
			.done_edges (done_edges[i])
		);
	end

	////////////////////////////////////////////////////////////
	// done counters
	////////////////////////////////////////////////////////////

	// several units may finish in the same cycle
	always_comb begin
		vertex_sum = '0;
		edge_sum   = '0;
		for (int i = 0; i < NUM_CU; i++) begin
			if (vertex_done[i]) begin
				vertex_sum = vertex_sum + 1'b1;
				edge_sum   = edge_sum + count_t'(done_edges[i]);
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertices_done <= '0;
			edges_done    <= '0;
		end else begin
			vertices_done <= vertices_done + vertex_sum;
			edges_done    <= edges_done + edge_sum;
		end
	end

endmodule

// ==== src/read_command_mux.sv ====
`timescale 1ns/1ps

module read_command_mux (
	input  logic                              clock,
	input  logic                              rstn,
	input  logic [graph_ctrl_pkg::NUM_CU-1:0] cmd_push,
	input  graph_ctrl_pkg::addr_t              cmd_addr [graph_ctrl_pkg::NUM_CU],
	output logic [graph_ctrl_pkg::NUM_CU-1:0] cmd_full,
	input  logic                              read_credit,
	output logic                              read_cmd_valid,
	output graph_ctrl_pkg::addr_t              read_cmd_addr,
	output graph_ctrl_pkg::cu_id_t             read_cmd_cu_id
);

	import graph_ctrl_pkg::*;

	addr_t               head [NUM_CU];
	logic [NUM_CU-1:0]   empty;
	logic [NUM_CU-1:0]   request;
	logic [NUM_CU-1:0]   grant;
	logic                issue;
	logic [CREDIT_W-1:0] credits;
	cu_id_t              grant_id;
	addr_t               grant_addr;

	////////////////////////////////////////////////////////////
	// per-unit command buffers
	////////////////////////////////////////////////////////////

	for (genvar i = 0; i < NUM_CU; i++) begin : g_cmd_fifo
		sync_fifo #(
			.WIDTH(ADDR_W),
			.DEPTH(CMD_FIFO_DEPTH)
		) u_cmd_fifo (
			.clock   (clock),
			.rstn    (rstn),
			.push    (cmd_push[i]),
			.data_in (cmd_addr[i]),
			.full    (cmd_full[i]),
			.pop     (grant[i]),
			.data_out(head[i]),
			.empty   (empty[i])
		);
	end

	////////////////////////////////////////////////////////////
	// merge and credit tracking
	////////////////////////////////////////////////////////////

	// nothing requests once credits run out
	assign request = ~empty & {NUM_CU{credits != '0}};
	assign issue   = |grant;

	rr_arbiter #(.N(NUM_CU)) u_cmd_arb (
		.clock  (clock),
		.rstn   (rstn),
		.request(request),
		.advance(issue),
		.grant  (grant)
	);

	always_comb begin
		grant_id   = '0;
		grant_addr = '0;
		for (int i = 0; i < NUM_CU; i++) begin
			if (grant[i]) begin
				grant_id   = cu_id_t'(i);
				grant_addr = head[i];
			end
		end
	end

	// credit is spent at grant, a cycle before the port shows it
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			credits <= CREDIT_W'(READ_CREDITS);
		else if (issue && !read_credit)
			credits <= credits - 1'b1;
		else if (read_credit && !issue)
			credits <= credits + 1'b1;
	end

	always_ff @(posedge clock) begin
		if (issue) begin
			read_cmd_addr  <= grant_addr;
			read_cmd_cu_id <= grant_id;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			read_cmd_valid <= 1'b0;
		else
			read_cmd_valid <= issue;
	end

endmodule

// ==== src/rr_arbiter.sv ====
`timescale 1ns/1ps

module rr_arbiter #(
	parameter int N = 4
) (
	input  logic         clock,
	input  logic         rstn,
	input  logic [N-1:0] request,
	input  logic         advance,
	output logic [N-1:0] grant
);

	localparam int PTR_W = (N > 1) ? $clog2(N) : 1;

	logic [PTR_W-1:0] last;
	logic [PTR_W-1:0] win;
	logic             found;

	// search starts one past the last winner
	always_comb begin
		int idx;
		grant = '0;
		win   = last;
		found = 1'b0;
		for (int i = 1; i <= N; i++) begin
			idx = (int'(last) + i) % N;
			if (!found && request[idx]) begin
				grant[idx] = 1'b1;
				win        = PTR_W'(idx);
				found      = 1'b1;
			end
		end
	end

	// start at N-1 so index 0 wins first
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			last <= PTR_W'(N - 1);
		else if (advance && found)
			last <= win;
	end

endmodule

// ==== src/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 16
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	output logic             full,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	assign do_push  = push && !full;
	assign do_pop   = pop && !empty;
	assign full     = (count == CNT_W'(DEPTH));
	assign empty    = (count == '0);
	// show-ahead, head entry always visible
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= data_in;
	end

	// pointers wrap explicitly so DEPTH need not be a power of two
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

endmodule

// ==== src/vertex_cu.sv ====
`timescale 1ns/1ps

module vertex_cu #(
	parameter int CU_ID = 0
) (
	input  logic                       clock,
	input  logic                       rstn,
	output logic                       cu_idle,
	input  logic                       job_valid,
	input  graph_ctrl_pkg::addr_t       job_base,
	input  graph_ctrl_pkg::edge_count_t job_edges,
	output logic                       cmd_push,
	output graph_ctrl_pkg::addr_t       cmd_addr,
	input  logic                       cmd_full,
	input  logic                       data_valid,
	input  graph_ctrl_pkg::data_t       data,
	output logic                       vertex_done,
	output graph_ctrl_pkg::edge_count_t done_edges
);

	import graph_ctrl_pkg::*;

	cu_state_e   state;
	addr_t       base;
	edge_count_t edges;
	edge_count_t issued;
	edge_count_t received;
	edge_count_t rx_next;

	// unit index must fit the tag routed by the top level
	if (CU_ID >= NUM_CU) begin : g_bad_cu_id
		$error("vertex_cu index out of range");
	end

	assign cu_idle    = (state == CU_IDLE);
	assign cmd_push   = (state == CU_ISSUE) && !cmd_full;
	assign cmd_addr   = base + addr_t'(issued);
	assign rx_next    = received + edge_count_t'(data_valid);
	// zero-edge jobs finish on their first cycle in CU_WAIT
	assign vertex_done = (state == CU_WAIT) && (rx_next == edges);
	assign done_edges  = edges;

	always_ff @(posedge clock) begin
		if (cu_idle && job_valid) begin
			base  <= job_base;
			edges <= job_edges;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state    <= CU_IDLE;
			issued   <= '0;
			received <= '0;
		end else begin
			case (state)
				CU_IDLE: begin
					if (job_valid) begin
						issued   <= '0;
						received <= '0;
						state    <= (job_edges == '0) ? CU_WAIT : CU_ISSUE;
					end
				end
				CU_ISSUE: begin
					// data can already come back while issuing
					received <= rx_next;
					if (cmd_push) begin
						issued <= issued + 1'b1;
						if (issued == edges - 1'b1)
							state <= CU_WAIT;
					end
				end
				CU_WAIT: begin
					received <= rx_next;
					if (vertex_done)
						state <= CU_IDLE;
				end
				default: state <= CU_IDLE;
			endcase
		end
	end

endmodule

// ==== src/vertex_job_dispatch.sv ====
`timescale 1ns/1ps

module vertex_job_dispatch (
	input  logic                              clock,
	input  logic                              rstn,
	input  logic                              job_valid,
	input  graph_ctrl_pkg::vertex_id_t         job_vertex,
	input  graph_ctrl_pkg::addr_t              job_base,
	input  graph_ctrl_pkg::edge_count_t        job_edges,
	output logic                              job_credit,
	input  logic [graph_ctrl_pkg::NUM_CU-1:0] cu_idle,
	output logic [graph_ctrl_pkg::NUM_CU-1:0] cu_job_valid,
	output graph_ctrl_pkg::addr_t              cu_job_base,
	output graph_ctrl_pkg::edge_count_t        cu_job_edges
);

	import graph_ctrl_pkg::*;

	localparam int JOB_W = VERTEX_W + ADDR_W + EDGE_W;

	logic [JOB_W-1:0]  head;
	logic              empty;
	logic              pop;
	logic [NUM_CU-1:0] request;
	logic [NUM_CU-1:0] grant;

	////////////////////////////////////////////////////////////
	// job buffer
	////////////////////////////////////////////////////////////

	// upstream credits keep this from overflowing
	sync_fifo #(
		.WIDTH(JOB_W),
		.DEPTH(JOB_FIFO_DEPTH)
	) u_job_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (job_valid),
		.data_in ({job_vertex, job_base, job_edges}),
		.full    (),
		.pop     (pop),
		.data_out(head),
		.empty   (empty)
	);

	////////////////////////////////////////////////////////////
	// handout
	////////////////////////////////////////////////////////////

	// a unit granted last cycle still reads idle, mask it out
	assign request = cu_idle & ~cu_job_valid & {NUM_CU{!empty}};
	assign pop     = |grant;

	rr_arbiter #(.N(NUM_CU)) u_job_arb (
		.clock  (clock),
		.rstn   (rstn),
		.request(request),
		.advance(pop),
		.grant  (grant)
	);

	always_ff @(posedge clock) begin
		if (pop) begin
			cu_job_base  <= head[ADDR_W+EDGE_W-1:EDGE_W];
			cu_job_edges <= head[EDGE_W-1:0];
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_job_valid <= '0;
			job_credit   <= 1'b0;
		end else begin
			cu_job_valid <= grant;
			job_credit   <= pop;
		end
	end

endmodule
